// File: gomoku_defines.svh
`ifndef GOMOKU_DEFINES_SVH
`define GOMOKU_DEFINES_SVH

// board geometry
`define GOMOKU_N 8 // cells per side
`define GOMOKU_RUN 5 // stones in a line for a win

// turn timer reloads, in seconds, two BCD digits
`define TURN_SECONDS 99
`define PENALTY_SECONDS 59 // once the mover has no lives left

// LED matrix and seven-segment scan
`define SCAN_DIV 4 // CLK_play cycles per row step

`endif

// File: gomoku_pkg.sv
package gomoku_pkg;

`include "gomoku_defines.svh"

	// board coordinate, y in the upper bits so {y,x} is the linear index
	typedef struct packed
	{
		logic [2:0] y;
		logic [2:0] x;
	} coord_t;

	// cursor seen as x/y or as a cell number 0..63
	typedef union packed
	{
		coord_t coord;
		logic [5:0] cell_index;
	} cell_addr_u;

	// one bit per cell, [row][column], 1 = stone
	typedef logic [`GOMOKU_N-1:0][`GOMOKU_N-1:0] plane_t;

	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
		logic place;
	} keys_t;

	typedef struct packed
	{
		logic [3:0] tens;
		logic [3:0] ones;
	} bcd2_t;

	typedef struct packed
	{
		logic [2:0] lives; // thermometer, 111 = all three left
		logic [1:0] wins; // thermometer, saturates at 11
	} score_t;

	typedef struct packed
	{
		logic p1;
		logic p2;
	} winner_t;

endpackage

// File: gomoku_ctrl.sv
`timescale 1ns/1ps

module gomoku_ctrl (
	input logic CLK_play,
	input logic iRST_N,
	input gomoku_pkg::keys_t keys,
	input logic new_game,
	input gomoku_pkg::cell_addr_u cursor,
	input gomoku_pkg::plane_t plane_p1,
	input gomoku_pkg::plane_t plane_p2,
	input logic five_p1,
	input logic five_p2,
	input logic expire,
	output logic place_p1,
	output logic place_p2,
	output logic timer_reload,
	output logic short_turn,
	output logic timer_run,
	output gomoku_pkg::score_t score_p1,
	output gomoku_pkg::score_t score_p2,
	output gomoku_pkg::winner_t winner
);

	logic turn; // 0 = p1 to move
	logic [2:0] lives_p1, lives_p2;
	logic [1:0] wins_p1, wins_p2;
	logic live;
	logic occupied;
	logic legal;
	logic timeout;

	//////////////////////////////////////////////////////////////
	// placement and turn passing

	assign live = ~(winner.p1 | winner.p2); // play frozen after a win
	assign occupied = plane_p1[cursor.coord.y][cursor.coord.x]
		| plane_p2[cursor.coord.y][cursor.coord.x];
	assign legal = keys.place & live & ~occupied & ~new_game;

	assign place_p1 = legal & ~turn;
	assign place_p2 = legal & turn;

	// a stone placed on the expiring tick still counts as a move
	assign timeout = expire & live & ~legal & ~new_game;

	assign timer_reload = legal;
	assign timer_run = live;

	// the reload serves the player who takes over
	assign short_turn = turn ? (lives_p1 == 3'b000) : (lives_p2 == 3'b000);

	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			turn <= 1'b0;
			lives_p1 <= 3'b111;
			lives_p2 <= 3'b111;
		end
		else if (new_game)
		begin
			turn <= 1'b0;
			lives_p1 <= 3'b111;
			lives_p2 <= 3'b111;
		end
		else
		begin
			if (legal | timeout)
				turn <= ~turn;
			if (timeout & ~turn)
				lives_p1 <= {lives_p1[1:0], 1'b0}; // 111 -> 110 -> 100 -> 000
			if (timeout & turn)
				lives_p2 <= {lives_p2[1:0], 1'b0};
		end
	end

	//////////////////////////////////////////////////////////////
	// winner register and win tally

	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			winner <= '0;
			wins_p1 <= 2'b00;
			wins_p2 <= 2'b00;
		end
		else if (new_game)
		begin
			if (winner.p1)
				wins_p1 <= {wins_p1[0], 1'b1}; // saturates at 11
			if (winner.p2)
				wins_p2 <= {wins_p2[0], 1'b1};
			winner <= '0;
		end
		else if (live)
		begin
			winner.p1 <= five_p1;
			winner.p2 <= five_p2;
		end
	end

	assign score_p1.lives = lives_p1;
	assign score_p1.wins = wins_p1;
	assign score_p2.lives = lives_p2;
	assign score_p2.wins = wins_p2;

endmodule

// File: cursor_mover.sv
`timescale 1ns/1ps

module cursor_mover (
	input logic CLK_play,
	input logic iRST_N,
	input gomoku_pkg::keys_t keys,
	input logic new_game,
	output gomoku_pkg::cell_addr_u cursor
);

	// 3-bit fields wrap modulo 8 on their own
	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
			cursor <= '0;
		else if (new_game)
			cursor <= '0; // back to 0,0
		else if (keys.up)
			cursor.coord.y <= cursor.coord.y + 3'd1;
		else if (keys.down)
			cursor.coord.y <= cursor.coord.y - 3'd1;
		else if (keys.left)
			cursor.coord.x <= cursor.coord.x - 3'd1;
		else if (keys.right)
			cursor.coord.x <= cursor.coord.x + 3'd1;
	end

endmodule

// File: board_store.sv
`timescale 1ns/1ps

module board_store (
	input logic CLK_play,
	input logic iRST_N,
	input gomoku_pkg::cell_addr_u cursor,
	input logic place_p1,
	input logic place_p2,
	input logic new_game,
	output gomoku_pkg::plane_t plane_p1,
	output gomoku_pkg::plane_t plane_p2
);

	logic [1:0][63:0] cells; // [player][cell_index]
	logic [1:0] place;

	assign place = {place_p2, place_p1};

	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
			cells <= '0;
		else if (new_game)
			cells <= '0; // clear both planes
		else
		begin
			for (int p = 0; p < 2; p++)
			begin
				if (place[p])
					cells[p][cursor.cell_index] <= 1'b1;
			end
		end
	end

	// linear index {y,x} lines up with plane[y][x]
	assign plane_p1 = cells[0];
	assign plane_p2 = cells[1];

endmodule

// File: five_row_detector.sv
`timescale 1ns/1ps
`include "gomoku_defines.svh"

module five_row_detector (
	input gomoku_pkg::plane_t plane,
	output logic five_found
);

	localparam int N = `GOMOKU_N;
	localparam int RUN = `GOMOKU_RUN;

	logic found_row, found_col, found_fall, found_rise;

	// every start cell from which a full run fits on the board
	always_comb
	begin
		logic hit;

		found_row = 1'b0;
		found_col = 1'b0;
		found_fall = 1'b0;
		found_rise = 1'b0;

		for (int y = 0; y < N; y++)
			for (int x = 0; x <= N - RUN; x++)
			begin
				hit = 1'b1;
				for (int k = 0; k < RUN; k++)
					hit &= plane[y][x + k]; // along a row
				found_row |= hit;
			end

		for (int x = 0; x < N; x++)
			for (int y = 0; y <= N - RUN; y++)
			begin
				hit = 1'b1;
				for (int k = 0; k < RUN; k++)
					hit &= plane[y + k][x]; // down a column
				found_col |= hit;
			end

		// x and y both increasing
		for (int y = 0; y <= N - RUN; y++)
			for (int x = 0; x <= N - RUN; x++)
			begin
				hit = 1'b1;
				for (int k = 0; k < RUN; k++)
					hit &= plane[y + k][x + k];
				found_fall |= hit;
			end

		// x increasing, y decreasing
		for (int y = RUN - 1; y < N; y++)
			for (int x = 0; x <= N - RUN; x++)
			begin
				hit = 1'b1;
				for (int k = 0; k < RUN; k++)
					hit &= plane[y - k][x + k];
				found_rise |= hit;
			end
	end

	assign five_found = found_row | found_col | found_fall | found_rise;

endmodule

// File: turn_timer.sv
`timescale 1ns/1ps
`include "gomoku_defines.svh"

module turn_timer (
	input logic CLK_play,
	input logic iRST_N,
	input logic sec_tick,
	input logic timer_reload,
	input logic short_turn,
	input logic timer_run,
	input logic new_game,
	output gomoku_pkg::bcd2_t digits,
	output logic expire
);

	localparam logic [3:0] TURN_TENS = 4'(`TURN_SECONDS / 10);
	localparam logic [3:0] TURN_ONES = 4'(`TURN_SECONDS % 10);
	localparam logic [3:0] PEN_TENS = 4'(`PENALTY_SECONDS / 10);
	localparam logic [3:0] PEN_ONES = 4'(`PENALTY_SECONDS % 10);

	gomoku_pkg::bcd2_t reload_val;

	assign reload_val.tens = short_turn ? PEN_TENS : TURN_TENS;
	assign reload_val.ones = short_turn ? PEN_ONES : TURN_ONES;

	// tick while showing 00
	assign expire = sec_tick & timer_run & (digits.tens == 4'd0) & (digits.ones == 4'd0);

	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			digits.tens <= TURN_TENS;
			digits.ones <= TURN_ONES;
		end
		else if (new_game)
		begin
			digits.tens <= TURN_TENS;
			digits.ones <= TURN_ONES;
		end
		else if (timer_reload | expire)
			digits <= reload_val;
		else if (sec_tick & timer_run)
		begin
			if (digits.ones == 4'd0)
			begin
				digits.ones <= 4'd9; // borrow from tens
				digits.tens <= digits.tens - 4'd1;
			end
			else
				digits.ones <= digits.ones - 4'd1;
		end
	end

endmodule

// File: display_scan.sv
`timescale 1ns/1ps
`include "gomoku_defines.svh"

module display_scan (
	input logic CLK_play,
	input logic iRST_N,
	input gomoku_pkg::plane_t plane_p1,
	input gomoku_pkg::plane_t plane_p2,
	input gomoku_pkg::cell_addr_u cursor,
	input gomoku_pkg::winner_t winner,
	input gomoku_pkg::bcd2_t digits,
	output logic [2:0] row_sel,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue,
	output logic [6:0] seg,
	output logic [1:0] seg_sel
);

	localparam int DIV = `SCAN_DIV;
	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;

	// win glyphs, row 0 first, 0 = lit
	localparam logic [7:0] GLYPH_P1 [8] = '{
		8'b11100111, 8'b11000111, 8'b10100111, 8'b11100111,
		8'b11100111, 8'b11100111, 8'b10000001, 8'b11111111
	};
	localparam logic [7:0] GLYPH_P2 [8] = '{
		8'b11000011, 8'b10011001, 8'b11111001, 8'b11110011,
		8'b11100111, 8'b11001111, 8'b10000001, 8'b11111111
	};

	logic [CNT_W-1:0] scan_cnt;
	logic step;

	//////////////////////////////////////////////////////////////
	// row and digit scan

	assign step = (scan_cnt == CNT_W'(DIV - 1));

	always_ff @(posedge CLK_play or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			scan_cnt <= '0;
			row_sel <= 3'd0;
			seg_sel <= 2'b01;
		end
		else if (step)
		begin
			scan_cnt <= '0;
			row_sel <= row_sel + 3'd1;
			seg_sel <= {seg_sel[0], seg_sel[1]}; // swap digits
		end
		else
			scan_cnt <= scan_cnt + 1'b1;
	end

	//////////////////////////////////////////////////////////////
	// pixel rows, active low

	always_comb
	begin
		red = ~plane_p1[row_sel];
		green = ~plane_p2[row_sel];
		blue = 8'hFF;
		if (winner.p1)
		begin
			red = GLYPH_P1[row_sel];
			green = 8'hFF;
		end
		else if (winner.p2)
		begin
			red = 8'hFF;
			green = GLYPH_P2[row_sel];
		end
		else if (cursor.coord.y == row_sel)
			blue[cursor.coord.x] = 1'b0; // cursor dot
	end

	// segments abcdefg, active low
	function automatic logic [6:0] seg_decode(input logic [3:0] d);
		case (d)
			4'd0: seg_decode = 7'b0000001;
			4'd1: seg_decode = 7'b1001111;
			4'd2: seg_decode = 7'b0010010;
			4'd3: seg_decode = 7'b0000110;
			4'd4: seg_decode = 7'b1001100;
			4'd5: seg_decode = 7'b0100100;
			4'd6: seg_decode = 7'b0100000;
			4'd7: seg_decode = 7'b0001111;
			4'd8: seg_decode = 7'b0000000;
			4'd9: seg_decode = 7'b0001100;
			default: seg_decode = 7'b1111111; // blank
		endcase
	endfunction

	assign seg = seg_decode(seg_sel[1] ? digits.tens : digits.ones); // 10 = tens

endmodule

// File: gomoku_top.sv
`timescale 1ns/1ps

module gomoku_top (
	input logic CLK_play,
	input logic iRST_N,
	input gomoku_pkg::keys_t keys,
	input logic new_game,
	input logic sec_tick,
	output logic [2:0] row_sel,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue,
	output logic [6:0] seg,
	output logic [1:0] seg_sel,
	output gomoku_pkg::score_t score_p1,
	output gomoku_pkg::score_t score_p2,
	output gomoku_pkg::winner_t winner
);

	gomoku_pkg::cell_addr_u cursor;
	gomoku_pkg::plane_t plane_p1, plane_p2;
	gomoku_pkg::bcd2_t digits;
	logic five_p1, five_p2;
	logic place_p1, place_p2;
	logic timer_reload, short_turn, timer_run;
	logic expire;

	gomoku_ctrl u_ctrl (
		.CLK_play(CLK_play),
		.iRST_N(iRST_N),
		.keys(keys),
		.new_game(new_game),
		.cursor(cursor),
		.plane_p1(plane_p1),
		.plane_p2(plane_p2),
		.five_p1(five_p1),
		.five_p2(five_p2),
		.expire(expire),
		.place_p1(place_p1),
		.place_p2(place_p2),
		.timer_reload(timer_reload),
		.short_turn(short_turn),
		.timer_run(timer_run),
		.score_p1(score_p1),
		.score_p2(score_p2),
		.winner(winner)
	);

	cursor_mover u_cursor (
		.CLK_play(CLK_play),
		.iRST_N(iRST_N),
		.keys(keys),
		.new_game(new_game),
		.cursor(cursor)
	);

	board_store u_board (
		.CLK_play(CLK_play),
		.iRST_N(iRST_N),
		.cursor(cursor),
		.place_p1(place_p1),
		.place_p2(place_p2),
		.new_game(new_game),
		.plane_p1(plane_p1),
		.plane_p2(plane_p2)
	);

	five_row_detector u_five_p1 (
		.plane(plane_p1),
		.five_found(five_p1)
	);

	five_row_detector u_five_p2 (
		.plane(plane_p2),
		.five_found(five_p2)
	);

	turn_timer u_timer (
		.CLK_play(CLK_play),
		.iRST_N(iRST_N),
		.sec_tick(sec_tick),
		.timer_reload(timer_reload),
		.short_turn(short_turn),
		.timer_run(timer_run),
		.new_game(new_game),
		.digits(digits),
		.expire(expire)
	);

	display_scan u_display (
		.CLK_play(CLK_play),
		.iRST_N(iRST_N),
		.plane_p1(plane_p1),
		.plane_p2(plane_p2),
		.cursor(cursor),
		.winner(winner),
		.digits(digits),
		.row_sel(row_sel),
		.red(red),
		.green(green),
		.blue(blue),
		.seg(seg),
		.seg_sel(seg_sel)
	);

endmodule

// File: gomoku_assert.sv
`timescale 1ns/1ps
`include "gomoku_defines.svh"

module gomoku_assert (
	input logic CLK_play,
	input logic iRST_N,
	input logic new_game,
	input logic sec_tick,
	input logic expire,
	input logic timer_reload,
	input gomoku_pkg::bcd2_t digits,
	input logic [6:0] seg,
	input logic [1:0] seg_sel,
	input logic [2:0] row_sel,
	input gomoku_pkg::score_t score_p1,
	input gomoku_pkg::score_t score_p2,
	input gomoku_pkg::winner_t winner
);

	localparam logic [7:0] TURN_BCD = {4'(`TURN_SECONDS / 10), 4'(`TURN_SECONDS % 10)};
	localparam logic [7:0] PEN_BCD = {4'(`PENALTY_SECONDS / 10), 4'(`PENALTY_SECONDS % 10)};

	int fail_count = 0;
	logic [7:0] count;
	logic [2:0] lives_p1, lives_p2;

	assign count = digits;
	assign lives_p1 = score_p1.lives;
	assign lives_p2 = score_p2.lives;

	// one BCD step down, 10 -> 09
	function automatic logic [7:0] bcd_down(input logic [7:0] v);
		if (v[3:0] == 4'd0)
			return {v[7:4] - 4'd1, 4'd9};
		return {v[7:4], v[3:0] - 4'd1};
	endfunction

	////////////////////////////////////////////////////////////
	// seven-segment and timer

	assert property (@(posedge CLK_play) disable iff (!iRST_N)
		seg inside {7'b0000001, 7'b1001111, 7'b0010010, 7'b0000110, 7'b1001100,
			7'b0100100, 7'b0100000, 7'b0001111, 7'b0000000, 7'b0001100})
	else
	begin
		fail_count++;
		$error("seg %b is not a digit", seg);
	end

	// timer only runs while nobody has won
	assert property (@(posedge CLK_play) disable iff (!iRST_N)
		expire == (sec_tick && winner == 2'b00 && count == 8'h00))
	else
	begin
		fail_count++;
		$error("expire %b with digits %h", expire, count);
	end

	assert property (@(posedge CLK_play) disable iff (!iRST_N)
		sec_tick && winner == 2'b00 && !timer_reload && !expire && !new_game
		|=> count == bcd_down($past(count)))
	else
	begin
		fail_count++;
		$error("countdown reached %h", count);
	end

	assert property (@(posedge CLK_play) disable iff (!iRST_N)
		(timer_reload || expire) && !new_game && lives_p1 == 3'b000 && lives_p2 == 3'b000
		|=> count == PEN_BCD)
	else
	begin
		fail_count++;
		$error("short reload shows %h", count);
	end

	assert property (@(posedge CLK_play) disable iff (!iRST_N)
		(timer_reload || expire) && !new_game && lives_p1 != 3'b000 && lives_p2 != 3'b000
		|=> count == TURN_BCD)
	else
	begin
		fail_count++;
		$error("normal reload shows %h", count);
	end

	////////////////////////////////////////////////////////////
	// row and digit scan

	assert property (@(posedge CLK_play) disable iff (!iRST_N)
		$past(iRST_N, `SCAN_DIV) |-> row_sel == $past(row_sel, `SCAN_DIV) + 3'd1)
	else
	begin
		fail_count++;
		$error("row_sel %0d off the scan rate", row_sel);
	end

	// digits swap with every row step
	assert property (@(posedge CLK_play) disable iff (!iRST_N)
		seg_sel == (row_sel[0] ? 2'b10 : 2'b01))
	else
	begin
		fail_count++;
		$error("seg_sel %b in row %0d", seg_sel, row_sel);
	end

	////////////////////////////////////////////////////////////
	// lives

	assert property (@(posedge CLK_play) disable iff (!iRST_N)
		!new_game |=> lives_p1 == $past(lives_p1) || lives_p1 == {$past(lives_p1[1:0]), 1'b0})
	else
	begin
		fail_count++;
		$error("p1 lives went to %b", lives_p1);
	end

	assert property (@(posedge CLK_play) disable iff (!iRST_N)
		!new_game |=> lives_p2 == $past(lives_p2) || lives_p2 == {$past(lives_p2[1:0]), 1'b0})
	else
	begin
		fail_count++;
		$error("p2 lives went to %b", lives_p2);
	end

	assert property (@(posedge CLK_play) disable iff (!iRST_N)
		new_game |=> lives_p1 == 3'b111 && lives_p2 == 3'b111)
	else
	begin
		fail_count++;
		$error("lives %b %b after a new game", lives_p1, lives_p2);
	end

endmodule

bind gomoku_top gomoku_assert u_assert (
	.CLK_play(CLK_play),
	.iRST_N(iRST_N),
	.new_game(new_game),
	.sec_tick(sec_tick),
	.expire(expire),
	.timer_reload(timer_reload),
	.digits(digits),
	.seg(seg),
	.seg_sel(seg_sel),
	.row_sel(row_sel),
	.score_p1(score_p1),
	.score_p2(score_p2),
	.winner(winner)
);

// File: tb_gomoku.sv
`timescale 1ns/1ps
`include "gomoku_defines.svh"

module tb_gomoku;

	localparam logic [4:0] KEY_UP = 5'b10000;
	localparam logic [4:0] KEY_DOWN = 5'b01000;
	localparam logic [4:0] KEY_LEFT = 5'b00100;
	localparam logic [4:0] KEY_RIGHT = 5'b00010;
	localparam logic [4:0] KEY_PLACE = 5'b00001;

	logic CLK_play;
	logic iRST_N;
	gomoku_pkg::keys_t keys;
	logic new_game;
	logic sec_tick;
	logic [2:0] row_sel;
	logic [7:0] red, green, blue;
	logic [6:0] seg;
	logic [1:0] seg_sel;
	gomoku_pkg::score_t score_p1, score_p2;
	gomoku_pkg::winner_t winner;

	// reference model of the game
	gomoku_pkg::cell_addr_u model_cur;
	gomoku_pkg::plane_t model_p1, model_p2;
	logic model_turn; // 0 = p1 to move
	logic [1:0] model_win; // {p1, p2}
	logic [1:0] model_wins_p1, model_wins_p2;
	int errors;
	int ticks;

	// cell indices {y,x}, p1 first, a repeated cell for p2 that must be refused
	logic [5:0] diag_moves [10] = '{0, 0, 7, 9, 50, 18, 5, 27, 47, 36};
	logic [5:0] row_moves [10] = '{0, 25, 63, 26, 48, 27, 15, 28, 51, 29};

	gomoku_top u_dut (
		.CLK_play(CLK_play),
		.iRST_N(iRST_N),
		.keys(keys),
		.new_game(new_game),
		.sec_tick(sec_tick),
		.row_sel(row_sel),
		.red(red),
		.green(green),
		.blue(blue),
		.seg(seg),
		.seg_sel(seg_sel),
		.score_p1(score_p1),
		.score_p2(score_p2),
		.winner(winner)
	);

	always #10 CLK_play = ~CLK_play;

	task automatic report_error(input string msg);
		errors++;
		$display("error %0t: %s", $time, msg);
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timed out waiting for %s", what);
		$display("Errors found");
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// stimulus

	task automatic press(input logic [4:0] code);
		gomoku_pkg::keys_t k;
		gomoku_pkg::coord_t c;
		k = code;
		c = model_cur.coord;
		@(posedge CLK_play);
		keys <= k;
		@(posedge CLK_play);
		keys <= '0;
		// DUT acts on this edge
		if (k.up)
			model_cur.coord.y = c.y + 3'd1;
		else if (k.down)
			model_cur.coord.y = c.y - 3'd1;
		else if (k.left)
			model_cur.coord.x = c.x - 3'd1;
		else if (k.right)
			model_cur.coord.x = c.x + 3'd1;
		else if (k.place && model_win == 2'b00 && !model_p1[c.y][c.x] && !model_p2[c.y][c.x])
		begin
			if (model_turn)
				model_p2[c.y][c.x] = 1'b1;
			else
				model_p1[c.y][c.x] = 1'b1;
			model_turn = ~model_turn;
		end
	endtask

	// hold the cursor until the scan shows its row
	task automatic wait_cursor_row();
		int cycles;
		cycles = 0;
		@(negedge CLK_play);
		while (row_sel != model_cur.coord.y && cycles < 8 * `SCAN_DIV)
		begin
			@(negedge CLK_play);
			cycles++;
		end
		if (row_sel != model_cur.coord.y)
			abort_on_timeout("the scan to reach the cursor row");
	endtask

	task automatic place_at(input logic [5:0] idx);
		gomoku_pkg::cell_addr_u t;
		t.cell_index = idx;
		while (model_cur.coord.x != t.coord.x)
			press(KEY_RIGHT);
		while (model_cur.coord.y != t.coord.y)
			press(KEY_UP);
		press(KEY_PLACE);
	endtask

	task automatic play_game(input logic [5:0] moves [10]);
		for (int i = 0; i < 10; i++)
		begin
			@(negedge CLK_play);
			assert (winner == 2'b00) // no early win
			else report_error($sformatf("winner %b before the last stone", winner));
			place_at(moves[i]);
		end
	endtask

	task automatic wait_winner(input logic [1:0] expected);
		int cycles;
		cycles = 0;
		while (winner == 2'b00 && cycles < 10)
		begin
			@(negedge CLK_play);
			cycles++;
		end
		if (winner == 2'b00)
			abort_on_timeout("the winner flag");
		else
		begin
			assert (winner == expected)
			else report_error($sformatf("winner %b, expected %b", winner, expected));
			model_win = expected;
			repeat (8 * `SCAN_DIV) @(posedge CLK_play); // one full glyph scan
		end
	endtask

	task automatic start_new_game();
		@(posedge CLK_play);
		new_game <= 1'b1;
		@(posedge CLK_play);
		new_game <= 1'b0;
		if (model_win[1])
			model_wins_p1 = {model_wins_p1[0], 1'b1};
		if (model_win[0])
			model_wins_p2 = {model_wins_p2[0], 1'b1};
		model_win = 2'b00;
		model_p1 = '0;
		model_p2 = '0;
		model_turn = 1'b0;
		model_cur = '0;
		@(negedge CLK_play);
		assert (score_p1 == {3'b111, model_wins_p1})
		else report_error($sformatf("score_p1 %b, expected 111%b", score_p1, model_wins_p1));
		assert (score_p2 == {3'b111, model_wins_p2})
		else report_error($sformatf("score_p2 %b, expected 111%b", score_p2, model_wins_p2));
	endtask

	task automatic pulse_tick();
		@(posedge CLK_play);
		sec_tick <= 1'b1;
		@(posedge CLK_play);
		sec_tick <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// display checks against the model

	always @(negedge CLK_play)
	begin
		if (iRST_N && winner == 2'b00)
		begin
			assert (blue == ((model_cur.coord.y == row_sel) ? ~(8'b1 << model_cur.coord.x) : 8'hFF))
			else report_error($sformatf("blue %b in row %0d, cursor at %0d,%0d", blue, row_sel,
				model_cur.coord.x, model_cur.coord.y));
			assert (red == ~model_p1[row_sel] && green == ~model_p2[row_sel])
			else report_error($sformatf("row %0d shows red %b green %b", row_sel, red, green));
		end
		else if (iRST_N)
		begin
			// glyph only in the winner's colour
			assert (blue == 8'hFF && (winner.p1 ? green == 8'hFF : red == 8'hFF))
			else report_error($sformatf("glyph row %0d red %b green %b blue %b", row_sel, red,
				green, blue));
		end
	end

	initial
	begin
		void'($urandom(3690));
		errors = 0;
		CLK_play = 1'b0;
		iRST_N = 1'b0;
		keys = '0;
		new_game = 1'b0;
		sec_tick = 1'b0;
		model_cur = '0;
		model_p1 = '0;
		model_p2 = '0;
		model_turn = 1'b0;
		model_win = 2'b00;
		model_wins_p1 = 2'b00;
		model_wins_p2 = 2'b00;
		repeat (10) @(posedge CLK_play);
		iRST_N <= 1'b1;

		press(KEY_LEFT); // wrap to x = 7
		wait_cursor_row();
		press(KEY_DOWN); // wrap to y = 7
		wait_cursor_row();
		for (int i = 0; i < 40; i++)
		begin
			case ($urandom_range(3, 0))
				0: press(KEY_UP);
				1: press(KEY_DOWN);
				2: press(KEY_LEFT);
				default: press(KEY_RIGHT);
			endcase
			wait_cursor_row();
		end
		start_new_game();

		// p1, p2, then p1 twice more so the tally saturates
		play_game(diag_moves);
		wait_winner(2'b10);
		start_new_game();
		play_game(row_moves);
		wait_winner(2'b01);
		start_new_game();
		for (int g = 0; g < 2; g++)
		begin
			play_game(diag_moves);
			wait_winner(2'b10);
			start_new_game();
		end

		// both players time out until no lives are left
		ticks = 0;
		while (!(score_p1.lives == 3'b000 && score_p2.lives == 3'b000) && ticks < 1200)
		begin
			pulse_tick();
			@(negedge CLK_play);
			ticks++;
		end
		if (!(score_p1.lives == 3'b000 && score_p2.lives == 3'b000))
			abort_on_timeout("both players to run out of lives");
		else
		begin
			repeat (70) pulse_tick(); // through one short turn
			start_new_game();

			$display("summary: %0d testbench errors, %0d assertion failures", errors,
				u_dut.u_assert.fail_count);
			if (errors == 0 && u_dut.u_assert.fail_count == 0)
				$display("No errors");
			else
				$display("Errors found");
			$finish;
		end
	end

endmodule

// File: sources.f
+incdir+.
gomoku_pkg.sv
gomoku_ctrl.sv
cursor_mover.sv
board_store.sv
five_row_detector.sv
turn_timer.sv
display_scan.sv
gomoku_top.sv
gomoku_assert.sv
tb_gomoku.sv

// File: Bender.yml
package:
  name: gomoku

export_include_dirs:
  - .

sources:
  - gomoku_pkg.sv
  - gomoku_ctrl.sv
  - cursor_mover.sv
  - board_store.sv
  - five_row_detector.sv
  - turn_timer.sv
  - display_scan.sv
  - gomoku_top.sv
  - target: test
    files:
      - gomoku_assert.sv
      - tb_gomoku.sv
